/* common/sv39_pkg.sv */
//##########################################################################
// Sv39 page-table format for the IOMMU page table walker
// Address and page number widths, the PTE layout,
// page levels and the walker states
//##########################################################################

package sv39_pkg;

    // Address widths
    localparam int unsigned VA_W    = 39;
    localparam int unsigned PA_W    = 56;

    // Page numbers and context tags
    localparam int unsigned PPN_W   = 44;
    localparam int unsigned VPN_W   = 27;
    localparam int unsigned PSCID_W = 20;

    // Sv39 PTE, most significant field first
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    // LVL1 maps 1G pages, LVL2 2M pages, LVL3 4K pages
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } ptw_state_e;

endpackage

/* common/iommu_pkg.sv */
//##########################################################################
// IOMMU fault cause codes and MSI write-through PTE layout
// Also the widths of the MSI PTE fields and of the
// interrupt file number
//##########################################################################

package iommu_pkg;

    localparam int unsigned CAUSE_W     = 12;
    localparam int unsigned IMSIC_NUM_W = 8;

    // MSI PTE field widths
    localparam int unsigned MSI_PPN_W  = 44;
    localparam int unsigned MSI_RSV1_W = 7;
    localparam int unsigned MSI_RSV2_W = 9;

    // Fault causes reported to the IOMMU
    localparam logic [CAUSE_W-1:0] INSTR_ACCESS_FAULT    = 12'd1;
    localparam logic [CAUSE_W-1:0] LOAD_PAGE_FAULT       = 12'd13;
    localparam logic [CAUSE_W-1:0] STORE_PAGE_FAULT      = 12'd15;
    localparam logic [CAUSE_W-1:0] TRANS_TYPE_DISALLOWED = 12'd260;
    localparam logic [CAUSE_W-1:0] MSI_PTE_INVALID       = 12'd262;
    localparam logic [CAUSE_W-1:0] MSI_PTE_MISCONFIGURED = 12'd263;
    localparam logic [CAUSE_W-1:0] PT_DATA_CORRUPTION    = 12'd274;

    typedef enum logic [1:0] {
        MSI_MRIF          = 2'd1,
        MSI_WRITE_THROUGH = 2'd3
    } msi_mode_e;

    // Write-through MSI PTE, most significant field first
    typedef struct packed {
        logic                  c;
        logic [MSI_RSV2_W-1:0] reserved_2;
        logic [MSI_PPN_W-1:0]  ppn;
        logic [MSI_RSV1_W-1:0] reserved_1;
        msi_mode_e             m;
        logic                  v;
    } msi_pte_t;

endpackage

/* ptw/pte_checker.sv */
//##########################################################################
// Sv39 PTE classification and fault checks
// Leaf or pointer, then validity, reserved bits, superpage
// alignment and the A/D/U rules per PTE kind
//##########################################################################

`timescale 1ns/1ps

module pte_checker
    import sv39_pkg::*;
(
    input  pte_t     pte_i,
    input  ptw_lvl_e level_i,
    input  logic     is_store_i,
    output logic     leaf_o,
    output logic     fault_o
);

    logic invalid;
    logic misaligned;
    logic leaf_bad;
    logic ptr_bad;

    // Any of R or X makes a leaf
    assign leaf_o = pte_i.r | pte_i.x;

    // V clear or write-only encoding
    assign invalid = !pte_i.v || (pte_i.w && !pte_i.r);

    // Superpages need the low PPN bits clear
    assign misaligned = ((level_i == LVL1) && (|pte_i.ppn[17:0])) ||
                        ((level_i == LVL2) && (|pte_i.ppn[8:0]));

    // Leaves need A and R, and D on stores
    assign leaf_bad = misaligned || !pte_i.a || !pte_i.r || (is_store_i && !pte_i.d);

    // A, D, U are reserved on pointers, and LVL3 has no next table
    assign ptr_bad = pte_i.a || pte_i.d || pte_i.u || (level_i == LVL3);

    assign fault_o = invalid || (|pte_i.reserved) || (leaf_o ? leaf_bad : ptr_bad);

    // Known PTE and level must give a known verdict
    always_comb begin
        if (!$isunknown({pte_i, level_i, is_store_i})) begin
            a_fault_known: assert (!$isunknown(fault_o));
        end
    end

endmodule

/* ptw/ptw_walk_fsm.sv */
//##########################################################################
// Sv39 walk state machine
// Level tracking, next pointer generation and the read handshake
// Ends each walk in one IOTLB update, one error report or a bare pass
// Stage-1 leaves in the IMSIC range are redirected to the MSI table
//##########################################################################

`timescale 1ns/1ps

module ptw_walk_fsm
    import sv39_pkg::*;
    import iommu_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               miss_i,
    input  logic [VA_W-1:0]    iova_i,
    input  logic               is_store_i,
    input  logic [PSCID_W-1:0] pscid_i,
    input  logic               en_1s_i,
    input  logic [PPN_W-1:0]   satp_ppn_i,
    output logic               ar_valid_o,
    output logic [PA_W-1:0]    ar_addr_o,
    input  logic               ar_ready_i,
    input  logic               r_valid_i,
    input  logic [63:0]        r_data_i,
    input  logic               r_err_i,
    output logic               r_ready_o,
    output logic               busy_o,
    output logic               bare_o,
    output logic               update_o,
    output logic [VPN_W-1:0]   up_vpn_o,
    output logic [PSCID_W-1:0] up_pscid_o,
    output logic               up_2m_o,
    output logic               up_1g_o,
    output logic               up_is_msi_o,
    output pte_t               up_pte_o,
    output logic               error_o,
    output logic [CAUSE_W-1:0] cause_o,
    input  logic               pte_leaf_i,
    input  logic               pte_fault_i,
    input  logic               msi_hit_i,
    input  logic [PA_W-1:0]    msi_pptr_i,
    input  logic               msi_fault_i,
    input  logic [CAUSE_W-1:0] msi_cause_i,
    output logic [PPN_W-1:0]   cand_ppn_o,
    output ptw_lvl_e           level_o
);

    ptw_state_e         state_q, state_n;
    ptw_lvl_e           level_q, level_n;
    logic               global_q, global_n;
    logic               msi_q, msi_n;
    logic [PA_W-1:0]    pptr_q, pptr_n;
    logic [VA_W-1:0]    iova_q, iova_n;
    logic [PSCID_W-1:0] pscid_q, pscid_n;
    logic [CAUSE_W-1:0] cause_q, cause_n;
    pte_t               leaf_q, leaf_n;
    pte_t               pte;
    msi_pte_t           msi_pte;

    assign pte     = pte_t'(r_data_i);
    assign msi_pte = msi_pte_t'(r_data_i);

    // IOVA page while idle, leaf target page during lookup
    assign cand_ppn_o = (state_q == IDLE) ? {{(PPN_W-VPN_W){1'b0}}, iova_i[VA_W-1:12]}
                                          : pte.ppn;
    assign level_o    = level_q;
    assign busy_o     = (state_q != IDLE);
    assign ar_addr_o  = pptr_q;

    // Update payload, qualified by update_o
    assign up_vpn_o    = iova_q[VA_W-1:12];
    assign up_pscid_o  = pscid_q;
    assign up_1g_o     = (level_q == LVL1);
    assign up_2m_o     = (level_q == LVL2);
    assign up_is_msi_o = msi_q;

    // MSI entries keep the leaf flags but take the MSI target page
    always_comb begin
        up_pte_o = msi_q ? leaf_q : pte;
        if (msi_q) begin
            up_pte_o.ppn = msi_pte.ppn;
        end
        up_pte_o.g = up_pte_o.g | global_q;
    end

    always_comb begin
        state_n    = state_q;
        level_n    = level_q;
        global_n   = global_q;
        msi_n      = msi_q;
        pptr_n     = pptr_q;
        iova_n     = iova_q;
        pscid_n    = pscid_q;
        cause_n    = cause_q;
        leaf_n     = leaf_q;
        ar_valid_o = 1'b0;
        r_ready_o  = 1'b0;
        bare_o     = 1'b0;
        update_o   = 1'b0;
        error_o    = 1'b0;
        cause_o    = '0;

        case (state_q)
            IDLE: begin
                level_n  = LVL1;
                global_n = 1'b0;
                msi_n    = 1'b0;
                leaf_n   = '0;
                iova_n   = iova_i;
                pscid_n  = pscid_i;
                if (miss_i) begin
                    if (en_1s_i) begin
                        // Root table indexed by VPN[2]
                        pptr_n  = {satp_ppn_i, iova_i[VA_W-1:30], 3'b0};
                        state_n = MEM_ACCESS;
                    end else if (msi_hit_i) begin
                        // IMSIC store without first stage goes straight to the MSI table
                        pptr_n  = msi_pptr_i;
                        msi_n   = 1'b1;
                        level_n = LVL3;
                        state_n = MEM_ACCESS;
                    end else begin
                        bare_o = 1'b1;
                    end
                end
            end

            MEM_ACCESS: begin
                ar_valid_o = 1'b1;
                if (ar_ready_i) begin
                    state_n = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (r_valid_i) begin
                    r_ready_o = 1'b1;
                    if (r_err_i) begin
                        cause_n = PT_DATA_CORRUPTION;
                        state_n = PROPAGATE_ERROR;
                    end else if (msi_q) begin
                        if (msi_fault_i) begin
                            cause_n = msi_cause_i;
                            state_n = PROPAGATE_ERROR;
                        end else begin
                            update_o = 1'b1;
                            state_n  = IDLE;
                        end
                    end else if (pte_fault_i) begin
                        // Page faults follow the original access type
                        cause_n = is_store_i ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                        state_n = PROPAGATE_ERROR;
                    end else if (pte_leaf_i) begin
                        leaf_n = pte;
                        if (msi_hit_i) begin
                            // Leaf lands in the IMSIC range, fetch the MSI PTE
                            pptr_n  = msi_pptr_i;
                            msi_n   = 1'b1;
                            level_n = LVL3;
                            state_n = MEM_ACCESS;
                        end else begin
                            update_o = 1'b1;
                            state_n  = IDLE;
                        end
                    end else begin
                        // Pointer PTE, descend one level
                        global_n = global_q | pte.g;
                        state_n  = MEM_ACCESS;
                        if (level_q == LVL1) begin
                            level_n = LVL2;
                            pptr_n  = {pte.ppn, iova_q[29:21], 3'b0};
                        end else begin
                            level_n = LVL3;
                            pptr_n  = {pte.ppn, iova_q[20:12], 3'b0};
                        end
                    end
                end
            end

            PROPAGATE_ERROR: begin
                error_o = 1'b1;
                cause_o = cause_q;
                state_n = IDLE;
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            level_q  <= LVL1;
            global_q <= 1'b0;
            msi_q    <= 1'b0;
        end else begin
            state_q  <= state_n;
            level_q  <= level_n;
            global_q <= global_n;
            msi_q    <= msi_n;
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q  <= pptr_n;
        iova_q  <= iova_n;
        pscid_q <= pscid_n;
        cause_q <= cause_n;
        leaf_q  <= leaf_n;
    end

    // Request must be held until the memory accepts it
    a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    // A walk ends in one kind of completion only
    a_one_completion: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_o && error_o));

endmodule

/* rtl/msi_xlate.sv */
//##########################################################################
// MSI write-through translation helpers
// IMSIC address match, interrupt file number extraction,
// MSI PTE address and MSI PTE fault checks
//##########################################################################

`timescale 1ns/1ps

module msi_xlate
    import sv39_pkg::*;
    import iommu_pkg::*;
(
    input  logic [PPN_W-1:0]   cand_ppn_i,
    input  logic               is_store_i,
    input  logic               is_rx_i,
    input  logic               msi_en_i,
    input  logic [PPN_W-1:0]   msiptp_ppn_i,
    input  logic [VPN_W-1:0]   msi_mask_i,
    input  logic [VPN_W-1:0]   msi_pattern_i,
    input  logic [63:0]        r_data_i,
    output logic               msi_hit_o,
    output logic [PA_W-1:0]    msi_pptr_o,
    output logic               msi_fault_o,
    output logic [CAUSE_W-1:0] msi_cause_o
);

    logic [PPN_W-1:0]       mask_ext;
    logic [PPN_W-1:0]       pattern_ext;
    logic [IMSIC_NUM_W-1:0] file_num;
    msi_pte_t               msi_pte;

    // Upper page bits are never masked and the pattern has them clear
    assign mask_ext    = {{(PPN_W-VPN_W){1'b0}}, msi_mask_i};
    assign pattern_ext = {{(PPN_W-VPN_W){1'b0}}, msi_pattern_i};

    assign msi_hit_o = msi_en_i && is_store_i &&
                       ((cand_ppn_i & ~mask_ext) == (pattern_ext & ~mask_ext));

    // Pack candidate bits at set mask positions, lowest first
    always_comb begin
        int unsigned k;
        k        = 0;
        file_num = '0;
        for (int unsigned i = 0; i < VPN_W; i++) begin
            if (msi_mask_i[i]) begin
                if (k < IMSIC_NUM_W) begin
                    file_num[k] = cand_ppn_i[i];
                end
                k = k + 1;
            end
        end
    end

    // 16-byte MSI PTEs indexed by interrupt file number
    assign msi_pptr_o = {msiptp_ppn_i, 12'b0} |
                        {{(PA_W-IMSIC_NUM_W-4){1'b0}}, file_num, 4'b0};

    assign msi_pte = msi_pte_t'(r_data_i);

    // Later checks override earlier ones
    always_comb begin
        msi_fault_o = 1'b0;
        msi_cause_o = '0;
        if (!msi_pte.v || msi_pte.c) begin
            msi_fault_o = 1'b1;
            msi_cause_o = MSI_PTE_INVALID;
        end
        if ((|msi_pte.reserved_1) || (|msi_pte.reserved_2)) begin
            msi_fault_o = 1'b1;
            msi_cause_o = MSI_PTE_MISCONFIGURED;
        end
        if (is_rx_i) begin
            msi_fault_o = 1'b1;
            msi_cause_o = INSTR_ACCESS_FAULT;
        end
        // MRIF mode is not supported
        if (msi_pte.m != MSI_WRITE_THROUGH) begin
            msi_fault_o = 1'b1;
            msi_cause_o = TRANS_TYPE_DISALLOWED;
        end
    end

endmodule

/* rtl/iommu_ptw.sv */
//##########################################################################
// IOMMU page table walker top level
// Single-stage Sv39 walk with MSI write-through translation
// Connects the walk FSM, the PTE checker and the MSI unit
//##########################################################################

`timescale 1ns/1ps

module iommu_ptw
    import sv39_pkg::*;
    import iommu_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_ni,

    // Request from the IOTLB miss path
    input  logic               miss_i,
    input  logic [VA_W-1:0]    iova_i,
    input  logic               is_store_i,
    input  logic               is_rx_i,
    input  logic [PSCID_W-1:0] pscid_i,
    input  logic               en_1s_i,
    input  logic [PPN_W-1:0]   satp_ppn_i,

    // MSI translation setup
    input  logic               msi_en_i,
    input  logic [PPN_W-1:0]   msiptp_ppn_i,
    input  logic [VPN_W-1:0]   msi_mask_i,
    input  logic [VPN_W-1:0]   msi_pattern_i,

    // Read-only memory port
    output logic               ar_valid_o,
    output logic [PA_W-1:0]    ar_addr_o,
    input  logic               ar_ready_i,
    input  logic               r_valid_i,
    input  logic [63:0]        r_data_i,
    input  logic               r_err_i,
    output logic               r_ready_o,

    // Completion and IOTLB update
    output logic               busy_o,
    output logic               bare_o,
    output logic               update_o,
    output logic [VPN_W-1:0]   up_vpn_o,
    output logic [PSCID_W-1:0] up_pscid_o,
    output logic               up_2m_o,
    output logic               up_1g_o,
    output logic               up_is_msi_o,
    output pte_t               up_pte_o,
    output logic               error_o,
    output logic [CAUSE_W-1:0] cause_o
);

    // Checker results for the PTE on the read data bus
    logic               pte_leaf;
    logic               pte_fault;
    ptw_lvl_e           level;

    // MSI match on the candidate page and MSI PTE checks
    logic [PPN_W-1:0]   cand_ppn;
    logic               msi_hit;
    logic [PA_W-1:0]    msi_pptr;
    logic               msi_fault;
    logic [CAUSE_W-1:0] msi_cause;

    ptw_walk_fsm u_walk (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .miss_i      (miss_i),
        .iova_i      (iova_i),
        .is_store_i  (is_store_i),
        .pscid_i     (pscid_i),
        .en_1s_i     (en_1s_i),
        .satp_ppn_i  (satp_ppn_i),
        .ar_valid_o  (ar_valid_o),
        .ar_addr_o   (ar_addr_o),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_data_i    (r_data_i),
        .r_err_i     (r_err_i),
        .r_ready_o   (r_ready_o),
        .busy_o      (busy_o),
        .bare_o      (bare_o),
        .update_o    (update_o),
        .up_vpn_o    (up_vpn_o),
        .up_pscid_o  (up_pscid_o),
        .up_2m_o     (up_2m_o),
        .up_1g_o     (up_1g_o),
        .up_is_msi_o (up_is_msi_o),
        .up_pte_o    (up_pte_o),
        .error_o     (error_o),
        .cause_o     (cause_o),
        .pte_leaf_i  (pte_leaf),
        .pte_fault_i (pte_fault),
        .msi_hit_i   (msi_hit),
        .msi_pptr_i  (msi_pptr),
        .msi_fault_i (msi_fault),
        .msi_cause_i (msi_cause),
        .cand_ppn_o  (cand_ppn),
        .level_o     (level)
    );

    pte_checker u_pte_chk (
        .pte_i      (r_data_i),
        .level_i    (level),
        .is_store_i (is_store_i),
        .leaf_o     (pte_leaf),
        .fault_o    (pte_fault)
    );

    msi_xlate u_msi (
        .cand_ppn_i    (cand_ppn),
        .is_store_i    (is_store_i),
        .is_rx_i       (is_rx_i),
        .msi_en_i      (msi_en_i),
        .msiptp_ppn_i  (msiptp_ppn_i),
        .msi_mask_i    (msi_mask_i),
        .msi_pattern_i (msi_pattern_i),
        .r_data_i      (r_data_i),
        .msi_hit_o     (msi_hit),
        .msi_pptr_o    (msi_pptr),
        .msi_fault_o   (msi_fault),
        .msi_cause_o   (msi_cause)
    );

endmodule

/* dv/ptw_mem_model.sv */
//##########################################################################
// Read-only memory model for the page table walker
// 64 KB as 8K 64-bit words, delayed ar_ready and r_valid,
// and an error response at one selectable address
//##########################################################################

`timescale 1ns/1ps

module ptw_mem_model
    import sv39_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            ar_valid_i,
    input  logic [PA_W-1:0] ar_addr_i,
    output logic            ar_ready_o,
    output logic            r_valid_o,
    output logic [63:0]     r_data_o,
    output logic            r_err_o,
    input  logic            r_ready_i,
    input  logic [PA_W-1:0] err_addr_i,
    input  logic [2:0]      ar_delay_i,
    input  logic [2:0]      r_delay_i
);

    logic [63:0]     mem [0:8191];
    logic [2:0]      cnt_q;
    logic            pending_q;
    logic [PA_W-1:0] addr_q;

    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = '0;
        end
    end

    task automatic load_word(input logic [PA_W-1:0] addr, input logic [63:0] data);
        mem[addr[15:3]] = data;
    endtask

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_data_o   <= '0;
            r_err_o    <= 1'b0;
            pending_q  <= 1'b0;
            cnt_q      <= 3'd0;
            addr_q     <= '0;
        end else if (!pending_q) begin
            // Address phase
            if (ar_valid_i && ar_ready_o) begin
                ar_ready_o <= 1'b0;
                pending_q  <= 1'b1;
                addr_q     <= ar_addr_i;
                cnt_q      <= r_delay_i;
            end else if (ar_valid_i) begin
                if (cnt_q == 3'd0) begin
                    ar_ready_o <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 3'd1;
                end
            end
        end else begin
            // Data phase holds r_valid until the walker takes it
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                pending_q <= 1'b0;
                cnt_q     <= ar_delay_i;
            end else if (!r_valid_o) begin
                if (cnt_q == 3'd0) begin
                    r_valid_o <= 1'b1;
                    r_data_o  <= mem[addr_q[15:3]];
                    r_err_o   <= (addr_q == err_addr_i);
                end else begin
                    cnt_q <= cnt_q - 3'd1;
                end
            end
        end
    end

endmodule

/* dv/tb_iommu_ptw.sv */
//##########################################################################
// Testbench top for the IOMMU page table walker
// Clock and reset, stimulus file reader, per-request checks,
// AR transfer monitor and a watchdog
//##########################################################################

`timescale 1ns/1ps

module tb_iommu_ptw
    import sv39_pkg::*;
    import iommu_pkg::*;
();

    logic               clk_i;
    logic               rst_ni;
    logic               miss;
    logic [VA_W-1:0]    iova;
    logic               is_store;
    logic               is_rx;
    logic [PSCID_W-1:0] pscid;
    logic               en_1s;
    logic [PPN_W-1:0]   satp_ppn;
    logic               msi_en;
    logic [PPN_W-1:0]   msiptp_ppn;
    logic [VPN_W-1:0]   msi_mask;
    logic [VPN_W-1:0]   msi_pattern;
    logic               ar_valid;
    logic [PA_W-1:0]    ar_addr;
    logic               ar_ready;
    logic               r_valid;
    logic [63:0]        r_data;
    logic               r_err;
    logic               r_ready;
    logic               busy;
    logic               bare;
    logic               update;
    logic [VPN_W-1:0]   up_vpn;
    logic [PSCID_W-1:0] up_pscid;
    logic               up_2m;
    logic               up_1g;
    logic               up_is_msi;
    pte_t               up_pte;
    logic               error;
    logic [CAUSE_W-1:0] cause;

    // Memory model controls
    logic [PA_W-1:0]    err_addr;
    logic [2:0]         ar_delay;
    logic [2:0]         r_delay;

    // Header words, memory pairs, then 13 words per request
    logic [63:0]        stim [0:511];
    int unsigned        n_req;
    logic               stim_ready;
    logic [31:0]        rng;
    logic [PA_W-1:0]    last_ar;

    iommu_ptw UUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .miss_i        (miss),
        .iova_i        (iova),
        .is_store_i    (is_store),
        .is_rx_i       (is_rx),
        .pscid_i       (pscid),
        .en_1s_i       (en_1s),
        .satp_ppn_i    (satp_ppn),
        .msi_en_i      (msi_en),
        .msiptp_ppn_i  (msiptp_ppn),
        .msi_mask_i    (msi_mask),
        .msi_pattern_i (msi_pattern),
        .ar_valid_o    (ar_valid),
        .ar_addr_o     (ar_addr),
        .ar_ready_i    (ar_ready),
        .r_valid_i     (r_valid),
        .r_data_i      (r_data),
        .r_err_i       (r_err),
        .r_ready_o     (r_ready),
        .busy_o        (busy),
        .bare_o        (bare),
        .update_o      (update),
        .up_vpn_o      (up_vpn),
        .up_pscid_o    (up_pscid),
        .up_2m_o       (up_2m),
        .up_1g_o       (up_1g),
        .up_is_msi_o   (up_is_msi),
        .up_pte_o      (up_pte),
        .error_o       (error),
        .cause_o       (cause)
    );

    ptw_mem_model u_mem (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ar_valid_i (ar_valid),
        .ar_addr_i  (ar_addr),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_data_o   (r_data),
        .r_err_o    (r_err),
        .r_ready_i  (r_ready),
        .err_addr_i (err_addr),
        .ar_delay_i (ar_delay),
        .r_delay_i  (r_delay)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Address of the latest AR transfer, sampled mid-cycle
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            last_ar <= '0;
        end else if (ar_valid && ar_ready) begin
            last_ar <= ar_addr;
        end
    end

    initial begin
        int unsigned n_mem;
        int unsigned base;
        string       tag;
        rst_ni      = 1'b0;
        miss        = 1'b0;
        iova        = '0;
        is_store    = 1'b0;
        is_rx       = 1'b0;
        pscid       = '0;
        en_1s       = 1'b0;
        satp_ppn    = '0;
        msi_en      = 1'b0;
        msiptp_ppn  = '0;
        msi_mask    = '0;
        msi_pattern = '0;
        err_addr    = '0;
        ar_delay    = 3'd0;
        r_delay     = 3'd0;
        rng         = 32'd87353;
        stim_ready  = 1'b0;
        $readmemh("dv/ptw_stim.txt", stim);
        n_mem = stim[0][31:0];
        n_req = stim[1][31:0];
        stim_ready = 1'b1;
        repeat (16) @(posedge clk_i);
        // Memory image goes in while reset is still held
        for (int unsigned i = 0; i < n_mem; i++) begin
            u_mem.load_word(stim[2+2*i][PA_W-1:0], stim[3+2*i]);
        end
        rst_ni <= 1'b1;
        @(posedge clk_i);
        // Handshake and completion outputs come out of reset low
        @(negedge clk_i);
        check_value("reset outputs", 64'd0,
                    64'({ar_valid, r_ready, busy, update, error, bare}));

        for (int unsigned r = 0; r < n_req; r++) begin
            base = 2 + 2 * n_mem + 13 * r;
            tag  = $sformatf("req%0d", r);
            @(posedge clk_i);
            rng = next_rand(rng);
            ar_delay <= 3'(rng % 32'd6);
            rng = next_rand(rng);
            r_delay     <= 3'(rng % 32'd6);
            iova        <= stim[base][VA_W-1:0];
            is_store    <= stim[base+1][0];
            is_rx       <= stim[base+1][1];
            en_1s       <= stim[base+1][2];
            msi_en      <= stim[base+1][3];
            pscid       <= stim[base+2][PSCID_W-1:0];
            satp_ppn    <= stim[base+3][PPN_W-1:0];
            msiptp_ppn  <= stim[base+4][PPN_W-1:0];
            msi_mask    <= stim[base+5][VPN_W-1:0];
            msi_pattern <= stim[base+6][VPN_W-1:0];
            err_addr    <= stim[base+11][PA_W-1:0];
            miss        <= 1'b1;

            // Wait for one of the three completion pulses
            @(negedge clk_i);
            while (!(bare || update || error)) begin
                @(negedge clk_i);
            end

            check_value({tag, " kind"}, stim[base+7], 64'({error, update, bare}));
            if (update) begin
                check_value({tag, " vpn"}, 64'(stim[base][VA_W-1:12]), 64'(up_vpn));
                check_value({tag, " pscid"}, stim[base+2], 64'(up_pscid));
                check_value({tag, " pte"}, stim[base+8], 64'(up_pte));
                check_value({tag, " size"}, stim[base+9], 64'({up_is_msi, up_1g, up_2m}));
            end
            if (error) begin
                check_value({tag, " cause"}, stim[base+10], 64'(cause));
            end
            if (bare) begin
                check_value({tag, " ar valid"}, 64'd0, 64'(ar_valid));
            end else begin
                check_value({tag, " last addr"}, stim[base+12], 64'(last_ar));
            end
            @(posedge clk_i);
            miss <= 1'b0;
            // Back in IDLE with no read request pending
            @(negedge clk_i);
            check_value({tag, " idle"}, 64'd0, 64'({busy, ar_valid}));
        end

        @(posedge clk_i);
        @(negedge clk_i);
        check_value("final busy", 64'd0, 64'(busy));
        $display("*** PASSED ***");
        $finish;
    end

    // Each request gets 200 cycles
    initial begin
        wait (stim_ready);
        repeat (n_req * 200 + 32) @(posedge clk_i);
        $display("Timeout: the walker did not finish all requests in time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* dv/ptw_stim.txt */
// Line 1 memory word count, line 2 request count, then memory lines: addr data
// Request: iova flags(0 st,1 rx,2 en_1s,3 msi_en) pscid satp msiptp mask pattern kind(1 bare,2 upd,4 err) pte size(0 2m,1 1g,2 msi) cause err_addr last_addr
f
10
1000 821
1008 100000C3
1010 100004C3
2008 C01
2010 800C3
3010 200C3
3018 20047
3020 1001
3028 A000CC7
8010 6
8020 F
8030 1DDC07
8040 1DDC07
8050 48D1407
8060 3
202000 4 12345 1 8 0 0 2 200E3 0 0 0 3010
40000000 4 1 1 8 0 0 2 100000C3 2 0 0 1008
400000 4 2 1 8 0 0 2 800E3 1 0 0 2010
80000000 4 3 1 8 0 0 4 0 0 D 0 1010
C0000000 5 4 1 8 0 0 4 0 0 F 0 1018
203000 5 5 1 8 0 0 4 0 0 F 0 3018
204000 4 6 1 8 0 0 4 0 0 D 0 3020
28005000 8 7 1 8 7 28000 1 0 0 0 0 0
28005000 9 8 1 8 7 28000 2 48D1400 4 0 0 8050
205000 D 9 1 8 7 28000 2 1DDCE7 4 0 0 8030
28001000 9 A 1 8 7 28000 4 0 0 106 0 8010
28002000 9 B 1 8 7 28000 4 0 0 107 0 8020
28004000 B C 1 8 7 28000 4 0 0 1 0 8040
28006000 B D 1 8 7 28000 4 0 0 104 0 8060
202000 4 E 1 8 0 0 4 0 0 112 2008 2008
28005000 9 F 1 8 7 28000 4 0 0 112 8050 8050

/* list.f */
common/sv39_pkg.sv
common/iommu_pkg.sv
ptw/pte_checker.sv
ptw/ptw_walk_fsm.sv
rtl/msi_xlate.sv
rtl/iommu_ptw.sv
dv/ptw_mem_model.sv
dv/tb_iommu_ptw.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_iommu_ptw
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
